//--- logic/proc_pkg.sv
package proc_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int xlen       = 32;     // Data and address width
    localparam int reg_addr_w = 5;      // Register index, also shamt width
    localparam int op_w       = 5;
    localparam int alu_op_w   = 5;
    localparam int imm_w      = 17;     // Sign-extended on decode
    localparam int target_w   = 27;     // Zero-extended on decode

    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;   // jal writes here

    // Field LSBs within the instruction word
    localparam int op_lsb     = 27;
    localparam int rd_lsb     = 22;
    localparam int rs_lsb     = 17;
    localparam int rt_lsb     = 12;
    localparam int shamt_lsb  = 7;
    localparam int alu_op_lsb = 2;

    // ----------------------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------------------
    typedef enum logic [op_w-1:0] {
        op_alu  = 5'b00000,             // R-type, function in alu_op field
        op_j    = 5'b00001,
        op_bne  = 5'b00010,
        op_jal  = 5'b00011,
        op_jr   = 5'b00100,
        op_addi = 5'b00101,
        op_blt  = 5'b00110,
        op_sw   = 5'b00111,
        op_lw   = 5'b01000
    } opcode_e;

    typedef enum logic [alu_op_w-1:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5                  // Arithmetic, keeps sign
    } alu_op_e;

    // ----------------------------------------------------------------------
    // Pipeline registers, valid low means bubble
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       instr;
    } fd_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        opcode_e               op;
        alu_op_e               alu_op;
        logic [reg_addr_w-1:0] rd;      // Already remapped for jal
        logic [reg_addr_w-1:0] shamt;
        logic [xlen-1:0]       a;       // Port A read data
        logic [xlen-1:0]       b;       // Port B read data
        logic [xlen-1:0]       imm;     // Immediate or jump target
        logic                  writes_reg;
    } dx_t;

    typedef struct packed {
        logic                  valid;
        opcode_e               op;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;  // ALU value, address or link
        logic [xlen-1:0]       store_data;
        logic                  writes_reg;
    } xm_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       value;
        logic                  writes_reg;
    } mw_t;

endpackage

//--- logic/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      redirect,
    input  logic [proc_pkg::xlen-1:0] redirect_pc,
    output logic [proc_pkg::xlen-1:0] address_imem,
    input  logic [proc_pkg::xlen-1:0] q_imem,
    output proc_pkg::fd_t             fd
);

    logic [proc_pkg::xlen-1:0] pc;

    assign address_imem = pc;           // Word addressed

    // ----------------------------------------------------------------------
    // Program counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;          // Execute wins over a held decode
        end else if (!stall) begin
            pc <= pc + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // FD register
    // ----------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (redirect || !stall) begin
            fd.pc    <= pc;
            fd.instr <= q_imem;
        end
        if (rst) begin
            fd.valid <= 1'b0;
        end else if (redirect) begin
            fd.valid <= 1'b0;           // Younger fetch squashed
        end else if (!stall) begin
            fd.valid <= 1'b1;
        end
    end

    // A squashed slot stays dead and the target is the next live fetch
    a_fd_squash : assert property (@(posedge clock) disable iff (rst)
        redirect |=> !fd.valid ##1 (fd.valid && (fd.pc == $past(redirect_pc, 2))));

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                            clock,
    input  logic                            rst,
    input  proc_pkg::fd_t                   fd,
    input  logic                            redirect,
    output logic [proc_pkg::reg_addr_w-1:0] ctrl_readRegA,
    output logic [proc_pkg::reg_addr_w-1:0] ctrl_readRegB,
    input  logic [proc_pkg::xlen-1:0]       data_readRegA,
    input  logic [proc_pkg::xlen-1:0]       data_readRegB,
    input  proc_pkg::xm_t                   xm,
    input  proc_pkg::mw_t                   mw,
    output logic                            stall,
    output proc_pkg::dx_t                   dx
);

    // True when an older valid writer targets src, r0 never counts
    function automatic logic pending(
        input logic                            v,
        input logic                            w,
        input logic [proc_pkg::reg_addr_w-1:0] dst,
        input logic [proc_pkg::reg_addr_w-1:0] src
    );
        return v && w && (dst == src) && (src != '0);
    endfunction

    proc_pkg::opcode_e               op;
    logic [proc_pkg::reg_addr_w-1:0] rd;
    logic [proc_pkg::reg_addr_w-1:0] rs;
    logic [proc_pkg::reg_addr_w-1:0] rt;
    logic [proc_pkg::reg_addr_w-1:0] dest;
    logic [proc_pkg::imm_w-1:0]      imm_f;
    logic [proc_pkg::target_w-1:0]   target_f;
    logic [proc_pkg::xlen-1:0]       imm_ext;
    logic                            is_branch;
    logic                            is_jump;
    logic                            reads_a;
    logic                            reads_b;
    logic                            writes;
    logic                            hazard_a;
    logic                            hazard_b;

    // ----------------------------------------------------------------------
    // Field split
    // ----------------------------------------------------------------------
    assign op       = proc_pkg::opcode_e'(fd.instr[proc_pkg::op_lsb +: proc_pkg::op_w]);
    assign rd       = fd.instr[proc_pkg::rd_lsb +: proc_pkg::reg_addr_w];
    assign rs       = fd.instr[proc_pkg::rs_lsb +: proc_pkg::reg_addr_w];
    assign rt       = fd.instr[proc_pkg::rt_lsb +: proc_pkg::reg_addr_w];
    assign imm_f    = fd.instr[proc_pkg::imm_w-1:0];
    assign target_f = fd.instr[proc_pkg::target_w-1:0];

    assign is_branch = (op == proc_pkg::op_bne) || (op == proc_pkg::op_blt);
    assign is_jump   = (op == proc_pkg::op_j) || (op == proc_pkg::op_jal);
    assign imm_ext   = is_jump ? {{(proc_pkg::xlen-proc_pkg::target_w){1'b0}}, target_f}
                               : {{(proc_pkg::xlen-proc_pkg::imm_w){imm_f[proc_pkg::imm_w-1]}},
                                  imm_f};

    // Register-file read selection
    assign ctrl_readRegA = (is_branch || op == proc_pkg::op_jr) ? rd : rs;
    always_comb begin
        case (op)
            proc_pkg::op_alu: ctrl_readRegB = rt;
            proc_pkg::op_sw:  ctrl_readRegB = rd;   // Store data
            default:          ctrl_readRegB = rs;   // Branch compare operand
        endcase
    end

    assign reads_a = !is_jump;          // Unknown opcodes read conservatively
    assign reads_b = (op == proc_pkg::op_alu) || (op == proc_pkg::op_sw) || is_branch;
    assign writes  = (op == proc_pkg::op_alu) || (op == proc_pkg::op_addi)
                  || (op == proc_pkg::op_lw) || (op == proc_pkg::op_jal);
    assign dest    = (op == proc_pkg::op_jal) ? proc_pkg::link_reg : rd;

    // ----------------------------------------------------------------------
    // RAW hazard, no bypass so any older writer stalls
    // ----------------------------------------------------------------------
    assign hazard_a = pending(dx.valid, dx.writes_reg, dx.rd, ctrl_readRegA)
                   || pending(xm.valid, xm.writes_reg, xm.rd, ctrl_readRegA)
                   || pending(mw.valid, mw.writes_reg, mw.rd, ctrl_readRegA);
    assign hazard_b = pending(dx.valid, dx.writes_reg, dx.rd, ctrl_readRegB)
                   || pending(xm.valid, xm.writes_reg, xm.rd, ctrl_readRegB)
                   || pending(mw.valid, mw.writes_reg, mw.rd, ctrl_readRegB);
    assign stall    = fd.valid && ((reads_a && hazard_a) || (reads_b && hazard_b));

    // DX register
    always_ff @(posedge clock) begin
        dx.pc         <= fd.pc;
        dx.op         <= op;
        dx.alu_op     <= (op == proc_pkg::op_alu)
                       ? proc_pkg::alu_op_e'(fd.instr[proc_pkg::alu_op_lsb +: proc_pkg::alu_op_w])
                       : proc_pkg::alu_add;     // Address and addi sums
        dx.rd         <= dest;
        dx.shamt      <= fd.instr[proc_pkg::shamt_lsb +: proc_pkg::reg_addr_w];
        dx.a          <= data_readRegA;
        dx.b          <= data_readRegB;
        dx.imm        <= imm_ext;
        dx.writes_reg <= writes && (dest != '0);
        if (rst) begin
            dx.valid <= 1'b0;
        end else begin
            dx.valid <= fd.valid && !stall && !redirect;   // Bubble otherwise
        end
    end

    // Held decode inserts a bubble while fetch keeps FD steady
    a_stall_bubble : assert property (@(posedge clock) disable iff (rst)
        stall && !redirect |=> !dx.valid && $stable(fd));

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
    input  logic                      clock,
    input  logic                      rst,
    input  proc_pkg::dx_t             dx,
    output logic                      redirect,
    output logic [proc_pkg::xlen-1:0] redirect_pc,
    output proc_pkg::xm_t             xm
);

    logic [proc_pkg::xlen-1:0] alu_b;
    logic [proc_pkg::xlen-1:0] alu_out;
    logic [proc_pkg::xlen-1:0] pc_plus1;
    logic [proc_pkg::xlen-1:0] branch_pc;
    logic                      taken;

    assign pc_plus1  = dx.pc + 1'b1;
    assign branch_pc = pc_plus1 + dx.imm;       // Relative to next word

    // ----------------------------------------------------------------------
    // ALU
    // ----------------------------------------------------------------------
    assign alu_b = (dx.op == proc_pkg::op_alu) ? dx.b : dx.imm;

    always_comb begin
        case (dx.alu_op)
            proc_pkg::alu_add: alu_out = dx.a + alu_b;
            proc_pkg::alu_sub: alu_out = dx.a - alu_b;
            proc_pkg::alu_and: alu_out = dx.a & alu_b;
            proc_pkg::alu_or:  alu_out = dx.a | alu_b;
            proc_pkg::alu_sll: alu_out = dx.a << dx.shamt;
            proc_pkg::alu_sra: alu_out = $signed(dx.a) >>> dx.shamt;
            default:           alu_out = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Branch and jump resolution
    // ----------------------------------------------------------------------
    always_comb begin
        taken       = 1'b0;
        redirect_pc = branch_pc;
        case (dx.op)
            proc_pkg::op_bne: taken = (dx.a != dx.b);   // a holds rd, b holds rs
            proc_pkg::op_blt: taken = ($signed(dx.a) < $signed(dx.b));
            proc_pkg::op_j, proc_pkg::op_jal: begin
                taken       = 1'b1;
                redirect_pc = dx.imm;                   // Absolute target
            end
            proc_pkg::op_jr: begin
                taken       = 1'b1;
                redirect_pc = dx.a;
            end
            default: taken = 1'b0;
        endcase
    end

    assign redirect = dx.valid && taken;

    // XM register
    always_ff @(posedge clock) begin
        xm.op         <= dx.op;
        xm.rd         <= dx.rd;
        xm.result     <= (dx.op == proc_pkg::op_jal) ? pc_plus1 : alu_out;
        xm.store_data <= dx.b;                          // rd value for sw
        xm.writes_reg <= dx.writes_reg;
        if (rst) begin
            xm.valid <= 1'b0;
        end else begin
            xm.valid <= dx.valid;
        end
    end

    // Redirect comes from a live instruction and squashes the one behind it
    a_redirect_live : assert property (@(posedge clock) disable iff (rst)
        redirect |-> dx.valid ##1 !dx.valid);

endmodule

//--- logic/writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage (
    input  logic                            clock,
    input  logic                            rst,
    input  proc_pkg::xm_t                   xm,
    output logic [proc_pkg::xlen-1:0]       address_dmem,
    output logic [proc_pkg::xlen-1:0]       data,
    output logic                            wren,
    input  logic [proc_pkg::xlen-1:0]       q_dmem,
    output proc_pkg::mw_t                   mw,
    output logic                            ctrl_writeEnable,
    output logic [proc_pkg::reg_addr_w-1:0] ctrl_writeReg,
    output logic [proc_pkg::xlen-1:0]       data_writeReg
);

    // ----------------------------------------------------------------------
    // Memory access, combinational from XM
    // ----------------------------------------------------------------------
    assign address_dmem = xm.result;            // rs plus imm
    assign data         = xm.store_data;
    assign wren         = xm.valid && (xm.op == proc_pkg::op_sw);

    // MW register
    always_ff @(posedge clock) begin
        mw.rd         <= xm.rd;
        mw.value      <= (xm.op == proc_pkg::op_lw) ? q_dmem : xm.result;
        mw.writes_reg <= xm.writes_reg;
        if (rst) begin
            mw.valid <= 1'b0;
        end else begin
            mw.valid <= xm.valid;
        end
    end

    // ----------------------------------------------------------------------
    // Register-file write
    // ----------------------------------------------------------------------
    assign ctrl_writeEnable = mw.valid && mw.writes_reg && (mw.rd != '0);
    assign ctrl_writeReg    = mw.rd;
    assign data_writeReg    = mw.value;

    // Decode never issues a live register write to r0
    a_no_r0_write : assert property (@(posedge clock) disable iff (rst)
        (xm.valid && xm.writes_reg) |-> (xm.rd != '0));

endmodule

//--- logic/processor.sv
`timescale 1ns/100ps

module processor (
    input  logic                            clock,
    input  logic                            rst,

    // Instruction memory
    output logic [proc_pkg::xlen-1:0]       address_imem,
    input  logic [proc_pkg::xlen-1:0]       q_imem,

    // Data memory
    output logic [proc_pkg::xlen-1:0]       address_dmem,
    output logic [proc_pkg::xlen-1:0]       data,
    output logic                            wren,
    input  logic [proc_pkg::xlen-1:0]       q_dmem,

    // Register file
    output logic                            ctrl_writeEnable,
    output logic [proc_pkg::reg_addr_w-1:0] ctrl_writeReg,
    output logic [proc_pkg::reg_addr_w-1:0] ctrl_readRegA,
    output logic [proc_pkg::reg_addr_w-1:0] ctrl_readRegB,
    output logic [proc_pkg::xlen-1:0]       data_writeReg,
    input  logic [proc_pkg::xlen-1:0]       data_readRegA,
    input  logic [proc_pkg::xlen-1:0]       data_readRegB
);

    // ----------------------------------------------------------------------
    // Stage links
    // ----------------------------------------------------------------------
    proc_pkg::fd_t             fd;
    proc_pkg::dx_t             dx;
    proc_pkg::xm_t             xm;
    proc_pkg::mw_t             mw;
    logic                      stall;       // Decode hazard hold
    logic                      redirect;    // Taken branch or jump in execute
    logic [proc_pkg::xlen-1:0] redirect_pc;

    fetch_stage u_fetch (
        .clock        (clock),
        .rst          (rst),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .fd           (fd)
    );

    decode_stage u_decode (
        .clock         (clock),
        .rst           (rst),
        .fd            (fd),
        .redirect      (redirect),
        .ctrl_readRegA (ctrl_readRegA),
        .ctrl_readRegB (ctrl_readRegB),
        .data_readRegA (data_readRegA),
        .data_readRegB (data_readRegB),
        .xm            (xm),
        .mw            (mw),
        .stall         (stall),
        .dx            (dx)
    );

    execute_stage u_execute (
        .clock       (clock),
        .rst         (rst),
        .dx          (dx),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .xm          (xm)
    );

    writeback_stage u_writeback (
        .clock            (clock),
        .rst              (rst),
        .xm               (xm),
        .address_dmem     (address_dmem),
        .data             (data),
        .wren             (wren),
        .q_dmem           (q_dmem),
        .mw               (mw),
        .ctrl_writeEnable (ctrl_writeEnable),
        .ctrl_writeReg    (ctrl_writeReg),
        .data_writeReg    (data_writeReg)
    );

endmodule

//--- dv/processor_tb.sv
`timescale 1ns/100ps

module processor_tb;

    localparam int mem_aw       = 8;
    localparam int mem_words    = 1 << mem_aw;
    localparam int reg_count    = 1 << proc_pkg::reg_addr_w;
    localparam int reset_cycles = 4;
    localparam int run_limit    = 2000;     // Cycles allowed to drain all expected events
    localparam int quiet_cycles = 40;       // Halt loop watched for stray events

    typedef struct packed {
        logic [proc_pkg::xlen-1:0] addr;    // Register index or data address
        logic [proc_pkg::xlen-1:0] value;
    } event_t;

    logic                            clock;
    logic                            rst;
    logic [proc_pkg::xlen-1:0]       address_imem;
    logic [proc_pkg::xlen-1:0]       q_imem;
    logic [proc_pkg::xlen-1:0]       address_dmem;
    logic [proc_pkg::xlen-1:0]       data;
    logic                            wren;
    logic [proc_pkg::xlen-1:0]       q_dmem;
    logic                            ctrl_writeEnable;
    logic [proc_pkg::reg_addr_w-1:0] ctrl_writeReg;
    logic [proc_pkg::reg_addr_w-1:0] ctrl_readRegA;
    logic [proc_pkg::reg_addr_w-1:0] ctrl_readRegB;
    logic [proc_pkg::xlen-1:0]       data_writeReg;
    logic [proc_pkg::xlen-1:0]       data_readRegA;
    logic [proc_pkg::xlen-1:0]       data_readRegB;

    logic [proc_pkg::xlen-1:0] imem [mem_words];
    logic [proc_pkg::xlen-1:0] dmem [mem_words];
    logic [proc_pkg::xlen-1:0] regs [reg_count];

    event_t exp_writes[$];                  // Program order
    event_t exp_stores[$];
    event_t next_write;
    event_t next_store;
    int     writes_seen;
    int     stores_seen;
    int     value_errors;
    int     other_errors;
    int     cycles;

    processor uut (
        .clock            (clock),
        .rst              (rst),
        .address_imem     (address_imem),
        .q_imem           (q_imem),
        .address_dmem     (address_dmem),
        .data             (data),
        .wren             (wren),
        .q_dmem           (q_dmem),
        .ctrl_writeEnable (ctrl_writeEnable),
        .ctrl_writeReg    (ctrl_writeReg),
        .ctrl_readRegA    (ctrl_readRegA),
        .ctrl_readRegB    (ctrl_readRegB),
        .data_writeReg    (data_writeReg),
        .data_readRegA    (data_readRegA),
        .data_readRegB    (data_readRegB)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;         // 20 ns period
    end

    // ----------------------------------------------------------------------
    // Memory and register-file models
    // ----------------------------------------------------------------------
    assign q_imem        = imem[address_imem[mem_aw-1:0]];
    assign q_dmem        = dmem[address_dmem[mem_aw-1:0]];
    assign data_readRegA = (ctrl_readRegA == '0) ? '0 : regs[ctrl_readRegA];   // r0 reads zero
    assign data_readRegB = (ctrl_readRegB == '0) ? '0 : regs[ctrl_readRegB];

    always @(posedge clock) begin
        if (wren) begin
            dmem[address_dmem[mem_aw-1:0]] <= data;
        end
        if (ctrl_writeEnable) begin
            regs[ctrl_writeReg] <= data_writeReg;
        end
    end

    task automatic check_value(input string name, input logic [proc_pkg::xlen-1:0] expected,
                               input logic [proc_pkg::xlen-1:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_problem(input string msg);
        other_errors++;
        $display("Error: %s", msg);
    endtask

    // Kind letter, then address or register and value in hex, # starts a comment
    task automatic load_stimulus();
        int                        stim_fd;
        int                        c;
        byte                       kind;
        event_t                    ev;
        logic [proc_pkg::xlen-1:0] a;
        logic [proc_pkg::xlen-1:0] b;
        stim_fd = $fopen("dv/program_stim.txt", "r");
        if (stim_fd == 0) begin
            report_problem("could not open dv/program_stim.txt");
            return;
        end
        while ($fscanf(stim_fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                c = $fgetc(stim_fd);                    // Skip rest of the line
                while (c != "\n" && c != -1) begin
                    c = $fgetc(stim_fd);
                end
            end else if ($fscanf(stim_fd, "%h %h", a, b) != 2) begin
                report_problem($sformatf("malformed stimulus line of kind %c", kind));
                break;
            end else begin
                ev.addr  = a;
                ev.value = b;
                case (kind)
                    "I": imem[a[mem_aw-1:0]] = b;
                    "D": dmem[a[mem_aw-1:0]] = b;
                    "W": exp_writes.push_back(ev);
                    "S": exp_stores.push_back(ev);
                    default: report_problem($sformatf("unknown stimulus kind %c", kind));
                endcase
            end
        end
        $fclose(stim_fd);
    endtask

    // ----------------------------------------------------------------------
    // Write and store monitor, outputs settle after the rising edge
    // ----------------------------------------------------------------------
    always @(negedge clock) begin
        if (ctrl_writeEnable) begin
            if (exp_writes.size() == 0) begin
                report_problem($sformatf("unexpected write of %h to register %0d",
                                         data_writeReg, ctrl_writeReg));
            end else begin
                next_write = exp_writes.pop_front();
                check_value($sformatf("write %0d register", writes_seen), next_write.addr,
                            ctrl_writeReg);
                check_value($sformatf("write %0d value", writes_seen), next_write.value,
                            data_writeReg);
            end
            writes_seen++;
        end
        if (wren) begin
            if (exp_stores.size() == 0) begin
                report_problem($sformatf("unexpected store of %h to address %h",
                                         data, address_dmem));
            end else begin
                next_store = exp_stores.pop_front();
                check_value($sformatf("store %0d address", stores_seen), next_store.addr,
                            address_dmem);
                check_value($sformatf("store %0d data", stores_seen), next_store.value, data);
            end
            stores_seen++;
        end
    end

    initial begin
        rst          = 1'b1;
        value_errors = 0;
        other_errors = 0;
        writes_seen  = 0;
        stores_seen  = 0;
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = '0;                                   // add r0, r0, r0
            dmem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0101);  // Address-dependent fill
        end
        for (int i = 0; i < reg_count; i++) begin
            regs[i] = '0;
        end
        load_stimulus();
        if (exp_writes.size() == 0) begin
            report_problem("the stimulus file holds no expected register writes");
        end

        // Reset held 4 cycles, released on a falling edge
        for (int i = 0; i < reset_cycles; i++) begin
            @(negedge clock);
            check_value("reset wren", '0, wren);
            check_value("reset ctrl_writeEnable", '0, ctrl_writeEnable);
            check_value("reset address_imem", '0, address_imem);
        end
        rst = 1'b0;
        @(negedge clock);
        check_value("first cycle wren", '0, wren);
        check_value("first cycle ctrl_writeEnable", '0, ctrl_writeEnable);

        cycles = 0;
        while ((exp_writes.size() + exp_stores.size() != 0) && cycles < run_limit) begin
            @(posedge clock);
            cycles++;
        end
        if (exp_writes.size() + exp_stores.size() != 0) begin
            report_problem("timeout while waiting for the expected writes and stores");
        end
        cycles = 0;
        while (cycles < quiet_cycles) begin             // Nothing more may be written
            @(posedge clock);
            cycles++;
        end
        if (exp_writes.size() != 0) begin
            report_problem($sformatf("%0d expected register writes never happened",
                                     exp_writes.size()));
        end
        if (exp_stores.size() != 0) begin
            report_problem($sformatf("%0d expected stores never happened", exp_stores.size()));
        end

        $display("Errors: %0d value mismatches, %0d other problems", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- dv/program_stim.txt
# Columns are kind, address or register, value, all hex
# Kinds I instruction word, D initial data word, W expected register write, S expected store
I 00 28400005 # addi r1, r0, 5
I 01 2881FFFD # addi r2, r0, -3
I 02 00C22000 # add  r3, r1, r2
I 03 01022004 # sub  r4, r1, r2
I 04 01422008 # and  r5, r1, r2
I 05 0182200C # or   r6, r1, r2
I 06 01C20210 # sll  r7, r1, 4
I 07 02040094 # sra  r8, r2, 1
I 08 2A400010 # addi r9, r0, 16
I 09 39D20004 # sw   r7, 4(r9)
I 0A 42920004 # lw   r10, 4(r9)
I 0B 10420005 # bne  r1, r1, +5 not taken
I 0C 30820002 # blt  r2, r1, +2 taken to 0F
I 0D 2AC00063 # squashed
I 0E 2B000063 # squashed
I 0F 30440003 # blt  r1, r2, +3 not taken
I 10 10440002 # bne  r1, r2, +2 taken to 13
I 11 38400000 # squashed store
I 12 2B40004D # squashed
I 13 1800001A # jal  1A
I 14 2B800001 # addi r14, r0, 1 after return
I 15 28020007 # addi r0, r1, 7 gives no write
I 16 42C00008 # lw   r11, 8(r0)
I 17 0800001E # j    1E
I 18 2B400042 # squashed
I 19 2B400042 # squashed
I 1A 2B3E0064 # addi r12, r31, 100
I 1B 27C00000 # jr   r31
I 1C 2B400037 # squashed
I 1D 38400000 # squashed store
I 1E 3B120000 # sw   r12, 0(r9)
I 1F 0800001F # j    1F halt loop
D 08 12345678
D 14 DEADBEEF # overwritten by the first store
W 01 00000005
W 02 FFFFFFFD
W 03 00000002
W 04 00000008
W 05 00000005
W 06 FFFFFFFD
W 07 00000050
W 08 FFFFFFFE
W 09 00000010
W 0A 00000050
W 1F 00000014 # link from jal
W 0C 00000078
W 0E 00000001
W 0B 12345678
S 14 00000050
S 10 00000078

//--- files.f
logic/proc_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/processor.sv
dv/processor_tb.sv

//--- Bender.yml
package:
  name: processor

sources:
  - logic/proc_pkg.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/writeback_stage.sv
  - logic/processor.sv
  - target: simulation
    files:
      - dv/processor_tb.sv
